/* dv/sprite_tb.sv */
`include "sprite_cfg.svh"

module sprite_tb;

	timeunit 1ns;
	timeprecision 1ps;

	// run limit in clock cycles
	localparam int WATCHDOG_CYCLES = 60000;

	logic       clk;
	logic       line_start;
	logic [8:0] vline;
	logic       spr_en;
	logic       sf_we;
	logic [7:0] sf_wa;
	logic [7:0] sf_wd;
	logic [5:0] spixel;
	logic       spx_en;

	// reference sprite file split into one array per field
	int m_act  [`SPR_COUNT];
	int m_pal  [`SPR_COUNT];
	int m_xpos [`SPR_COUNT];
	int m_xsz  [`SPR_COUNT];
	int m_ypos [`SPR_COUNT];
	int m_ysz  [`SPR_COUNT];

	logic [31:0] rng = 32'd95669;
	int checks = 0;
	int errors = 0;
	int err_mark = 0;
	int tests = 0;
	int failing = 0;

	sprite_engine u_dut (
		.clk        (clk),
		.line_start (line_start),
		.vline      (vline),
		.spr_en     (spr_en),
		.sf_we      (sf_we),
		.sf_wa      (sf_wa),
		.sf_wd      (sf_wd),
		.spixel     (spixel),
		.spx_en     (spx_en)
	);

	// 10 ns clock
	always #5 clk = ~clk;

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] t;
		t = s;
		t ^= t << 13;
		t ^= t >> 17;
		t ^= t << 5;
		return t;
	endfunction

	task automatic draw(output logic [31:0] r);
		rng = xorshift32(rng);
		r = rng;
	endtask

	task automatic check_val(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		checks++;
		if (got !== expected)
		begin
			errors++;
			$display("error at %0t: %s is %0d, expected %0d", $time, name, got, expected);
		end
	endtask

	// decode one byte into the reference fields by the register map
	task automatic model_write(input logic [7:0] a, input logic [7:0] d);
		int s;
		s = int'(a[7:3]);
		case (a[2:0])
			3'd0:
			begin
				m_act[s] = int'(d[7]);
				m_pal[s] = int'(d[5:0]);
			end
			3'd4:
				m_xpos[s] = (m_xpos[s] & 256) | int'(d);
			3'd5:
			begin
				m_xpos[s] = (m_xpos[s] & 255) | (int'(d[0]) * 256);
				m_xsz[s] = int'(d[7:1]);
			end
			3'd6:
				m_ypos[s] = (m_ypos[s] & 256) | int'(d);
			3'd7:
			begin
				m_ypos[s] = (m_ypos[s] & 255) | (int'(d[0]) * 256);
				m_ysz[s] = int'(d[7:1]);
			end
			default:
			begin
			end
		endcase
	endtask

	task automatic write_byte(input logic [7:0] a, input logic [7:0] d);
		@(posedge clk);
		sf_we <= 1'b1;
		sf_wa <= a;
		sf_wd <= d;
		model_write(a, d);
	endtask

	// last byte is taken on this edge
	task automatic write_done();
		@(posedge clk);
		sf_we <= 1'b0;
	endtask

	// writes all 8 registers
	// pattern bytes and bit 6 get random filler
	task automatic write_sprite(input int s, input int act, input int pal,
		input int xpos, input int xsz, input int ypos, input int ysz);
		logic [31:0] r;
		logic [7:0]  base;
		logic [8:0]  xp;
		logic [8:0]  yp;
		logic [6:0]  xs;
		logic [6:0]  ys;
		draw(r);
		base = {5'(s), 3'd0};
		xp = 9'(xpos);
		yp = 9'(ypos);
		xs = 7'(xsz);
		ys = 7'(ysz);
		write_byte(base, {act[0], r[0], 6'(pal)});
		write_byte(base | 8'd1, r[15:8]);
		write_byte(base | 8'd2, r[23:16]);
		write_byte(base | 8'd3, r[31:24]);
		write_byte(base | 8'd4, xp[7:0]);
		write_byte(base | 8'd5, {xs, xp[8]});
		write_byte(base | 8'd6, yp[7:0]);
		write_byte(base | 8'd7, {ys, yp[8]});
	endtask

	task automatic random_sprite(input int s);
		logic [31:0] a;
		logic [31:0] b;
		draw(a);
		draw(b);
		// mostly active
		write_sprite(s, (a[2:0] != 3'd0) ? 1 : 0, int'(a[8:3]), int'(a[17:9]),
			int'(a[24:18]), int'(b[8:0]), int'(b[15:9]));
	endtask

	task automatic clear_all();
		for (int s = 0; s < `SPR_COUNT; s++)
			write_sprite(s, 0, 0, 0, 0, 0, 0);
		write_done();
	endtask

	// first 8 active sprites on the line take the lanes
	// lowest sprite number covering x wins
	task automatic expect_pixel(input int v, input int x, output int hit, output int pal);
		int n;
		hit = 0;
		pal = 0;
		n = 0;
		for (int s = 0; s < `SPR_COUNT; s++)
		begin
			if (n < `SPR_LANES && m_act[s] != 0
				&& v >= m_ypos[s] && v < m_ypos[s] + m_ysz[s])
			begin
				n++;
				if (hit == 0 && x >= m_xpos[s] && x < m_xpos[s] + m_xsz[s])
				begin
					hit = 1;
					pal = m_pal[s];
				end
			end
		end
	endtask

	// one full line with every timer value checked one cycle later
	task automatic run_line(input int v, input int en, output int shown);
		int hit;
		int pal;
		shown = 0;
		@(posedge clk);
		line_start <= 1'b1;
		vline <= 9'(v);
		spr_en <= (en != 0);
		// outputs cleared while the line restarts
		@(negedge clk);
		check_val("spx_en", {31'b0, spx_en}, 32'd0);
		check_val("spixel", {26'b0, spixel}, 32'd0);
		@(posedge clk);
		line_start <= 1'b0;
		for (int h = 0; h < `LINE_CYCLES; h++)
		begin
			@(posedge clk);
			@(negedge clk);
			hit = 0;
			pal = 0;
			// blanking shows nothing
			if (h >= `HBLANK_CYCLES)
				expect_pixel(v, h - `HBLANK_CYCLES, hit, pal);
			check_val("spx_en", {31'b0, spx_en}, (hit != 0 && en != 0) ? 32'd1 : 32'd0);
			check_val("spixel", {26'b0, spixel}, (hit != 0) ? 32'(pal) : 32'd0);
			if (spx_en === 1'b1)
				shown++;
		end
	endtask

	task automatic end_test(input string name);
		tests++;
		if (errors == err_mark)
			$display("test %s: ok", name);
		else
		begin
			failing++;
			$display("test %s: %0d mismatches", name, errors - err_mark);
		end
		err_mark = errors;
	endtask

	initial
	begin
		int shown;
		logic [31:0] r;
		clk = 1'b0;
		line_start = 1'b1;
		vline = '0;
		spr_en = 1'b0;
		sf_we = 1'b0;
		sf_wa = '0;
		sf_wd = '0;
		repeat (2) @(posedge clk);
		line_start <= 1'b0;

		// inactive sprites whose spans cover line 100
		for (int s = 0; s < `SPR_COUNT; s++)
			write_sprite(s, 0, s + 1, s * 10, 20, 90, 20);
		write_done();
		run_line(100, 1, shown);
		check_val("spx_en count", 32'(shown), 32'd0);
		// same spans active but with zero height
		for (int s = 0; s < `SPR_COUNT; s++)
			write_sprite(s, 1, s + 1, s * 10, 20, 100, 0);
		write_done();
		run_line(100, 1, shown);
		check_val("spx_en count", 32'(shown), 32'd0);
		end_test("empty lines");

		// lone sprite checked above, inside and below its lines
		clear_all();
		write_sprite(5, 1, 21, 100, 40, 50, 10);
		write_done();
		run_line(49, 1, shown);
		check_val("spx_en count", 32'(shown), 32'd0);
		run_line(50, 1, shown);
		check_val("spx_en count", 32'(shown), 32'd40);
		run_line(55, 1, shown);
		run_line(59, 1, shown);
		check_val("spx_en count", 32'(shown), 32'd40);
		run_line(60, 1, shown);
		check_val("spx_en count", 32'(shown), 32'd0);
		// right edge clip at x 359
		write_sprite(5, 1, 22, 340, 50, 50, 10);
		write_done();
		run_line(52, 1, shown);
		check_val("spx_en count", 32'(shown), 32'd20);
		// entirely past the visible width
		write_sprite(5, 1, 23, 400, 30, 50, 10);
		write_done();
		run_line(52, 1, shown);
		check_val("spx_en count", 32'(shown), 32'd0);
		end_test("single sprite");

		// sprite 3 on top in the overlap at x 80..109
		clear_all();
		write_sprite(3, 1, 10, 50, 60, 200, 20);
		write_sprite(9, 1, 33, 80, 60, 200, 20);
		write_done();
		run_line(205, 1, shown);
		check_val("spx_en count", 32'(shown), 32'd90);
		end_test("overlap priority");

		// twelve on one line at odd sprite numbers
		// only the first eight fit in the lanes
		clear_all();
		for (int i = 0; i < 12; i++)
			write_sprite(2 * i + 1, 1, i + 1, 20 + 28 * i, 20, 300, 5);
		write_done();
		run_line(302, 1, shown);
		check_val("spx_en count", 32'(shown), 32'd160);
		end_test("lane limit");

		// same scene with the enable off and then on again
		run_line(302, 0, shown);
		check_val("spx_en count", 32'(shown), 32'd0);
		run_line(302, 1, shown);
		check_val("spx_en count", 32'(shown), 32'd160);
		end_test("enable gating");

		// random scenes with 8 sprites rewritten after each line
		for (int s = 0; s < `SPR_COUNT; s++)
			random_sprite(s);
		write_done();
		for (int l = 0; l < 40; l++)
		begin
			draw(r);
			run_line(int'(r[8:0]), (r[11:10] != 2'd0) ? 1 : 0, shown);
			for (int k = 0; k < 8; k++)
			begin
				draw(r);
				random_sprite(int'(r[4:0]));
			end
			write_done();
		end
		end_test("random lines");

		$display("%0d tests, %0d failing, %0d checks, %0d errors",
			tests, failing, checks, errors);
		if (errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

	// hang guard
	initial
	begin
		for (int c = 0; c < WATCHDOG_CYCLES; c++)
			@(posedge clk);
		$display("timeout: run did not complete within %0d cycles", WATCHDOG_CYCLES);
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule

/* run_sim.sh */
#!/bin/sh
# build and run the sprite_engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
	--top-module sprite_tb -f sprite_engine.f -o sprite_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/sprite_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "SIMULATION PASSED"; then
	exit 0
fi
exit 1

/* sprite_engine.f */
+incdir+src
src/sprite_pkg.sv
src/sprite_file.sv
src/sprite_scan.sv
src/sprite_lane.sv
src/sprite_mixer.sv
src/sprite_engine.sv
dv/sprite_tb.sv

/* src/sprite_cfg.svh */
`ifndef SPRITE_CFG_SVH
`define SPRITE_CFG_SVH

// descriptors held in the sprite file
`define SPR_COUNT 32

// lanes, i.e. most sprites shown on one line
`define SPR_LANES 8

// full tv line in clock cycles
`define LINE_CYCLES 448

// line timer value of screen x 0
`define HBLANK_CYCLES 88

// visible pixels per line
`define VIS_WIDTH 360

`endif

/* src/sprite_engine.sv */
`include "sprite_cfg.svh"

module sprite_engine import sprite_pkg::*;
(
	input  logic       clk,
	input  logic       line_start,
	input  logic [8:0] vline,
	input  logic       spr_en,
	input  logic       sf_we,
	input  logic [7:0] sf_wa,
	input  logic [7:0] sf_wd,
	output logic [5:0] spixel,
	output logic       spx_en
);

	// sprite file read path
	logic [4:0] rd_addr;
	spr_desc_t  rd_desc;

	// scanner to lanes
	logic [`SPR_LANES-1:0] lane_load;
	lane_load_t            load_data;
	screen_x_t             screen_x;

	// lanes to mixer
	lane_hit_t lane_hits [`SPR_LANES];

	// descriptor storage, written by the cpu port
	sprite_file u_file (
		.clk     (clk),
		.sf_we   (sf_we),
		.sf_wa   (sf_wa),
		.sf_wd   (sf_wd),
		.rd_addr (rd_addr),
		.rd_desc (rd_desc)
	);

	// line timer and per-line descriptor walk
	sprite_scan u_scan (
		.clk        (clk),
		.line_start (line_start),
		.vline      (vline),
		.rd_desc    (rd_desc),
		.rd_addr    (rd_addr),
		.lane_load  (lane_load),
		.load_data  (load_data),
		.screen_x   (screen_x)
	);

	// one lane per sprite that can show on a line
	for (genvar i = 0; i < `SPR_LANES; i++)
	begin : g_lane
		sprite_lane u_lane (
			.clk        (clk),
			.line_start (line_start),
			.load       (lane_load[i]),
			.load_data  (load_data),
			.screen_x   (screen_x),
			.lane_out   (lane_hits[i])
		);
	end

	// priority pick and output register
	sprite_mixer u_mixer (
		.clk        (clk),
		.line_start (line_start),
		.spr_en     (spr_en),
		.lane_in    (lane_hits),
		.spixel     (spixel),
		.spx_en     (spx_en)
	);

endmodule

/* src/sprite_file.sv */
`include "sprite_cfg.svh"

module sprite_file import sprite_pkg::*;
(
	input  logic      clk,
	input  logic      sf_we,
	input  logic [7:0] sf_wa,
	input  logic [7:0] sf_wd,
	input  logic [4:0] rd_addr,
	output spr_desc_t rd_desc
);

	// descriptor storage, one entry per sprite
	spr_desc_t mem [`SPR_COUNT];

	// byte writes
	// upper 5 address bits pick the sprite, lower 3 the register
	always_ff @(posedge clk)
	begin
		if (sf_we)
		begin
			case (sf_wa[2:0])
				3'd0:
				begin
					mem[sf_wa[7:3]].act <= sf_wd[7];
					// bit 6 is colour resolution, dropped
					mem[sf_wa[7:3]].pal <= sf_wd[5:0];
				end
				3'd4:
					mem[sf_wa[7:3]].xpos[7:0] <= sf_wd;
				3'd5:
				begin
					mem[sf_wa[7:3]].xpos[8] <= sf_wd[0];
					mem[sf_wa[7:3]].xsz <= sf_wd[7:1];
				end
				3'd6:
					mem[sf_wa[7:3]].ypos[7:0] <= sf_wd;
				3'd7:
				begin
					mem[sf_wa[7:3]].ypos[8] <= sf_wd[0];
					mem[sf_wa[7:3]].ysz <= sf_wd[7:1];
				end
				// regs 1..3 hold the pattern address, not used here
				default:
				begin
				end
			endcase
		end
	end

	// registered read, data one cycle after the address
	always_ff @(posedge clk)
	begin
		rd_desc <= mem[rd_addr];
	end

endmodule

/* src/sprite_lane.sv */
module sprite_lane import sprite_pkg::*;
(
	input  logic       clk,
	input  logic       line_start,
	input  logic       load,
	input  lane_load_t load_data,
	input  screen_x_t  screen_x,
	output lane_hit_t  lane_out
);

	logic       loaded;
	logic [8:0] xpos;
	logic [6:0] xsz;
	logic [5:0] pal;
	logic [9:0] x_end;

	// lane empty at the start of every line
	always_ff @(posedge clk, posedge line_start)
	begin
		if (line_start)
			loaded <= 1'b0;
		else if (load)
			loaded <= 1'b1;
	end

	// sprite span and colour, only valid while loaded
	always_ff @(posedge clk)
	begin
		if (load)
		begin
			xpos <= load_data.xpos;
			xsz  <= load_data.xsz;
			pal  <= load_data.pal;
		end
	end

	// end of span, one past the last pixel
	assign x_end = {1'b0, xpos} + {3'b000, xsz};

	// horizontal containment for the current pixel
	// blanking never hits, so nothing shows past x 359
	assign lane_out.hit = loaded
		&& screen_x.vis
		&& (screen_x.x >= xpos)
		&& ({1'b0, screen_x.x} < x_end);
	assign lane_out.pal = pal;

endmodule

/* src/sprite_mixer.sv */
`include "sprite_cfg.svh"

module sprite_mixer import sprite_pkg::*;
(
	input  logic       clk,
	input  logic       line_start,
	input  logic       spr_en,
	input  lane_hit_t  lane_in [`SPR_LANES],
	output logic [5:0] spixel,
	output logic       spx_en
);

	logic       sel_hit;
	logic [5:0] sel_pal;

	// priority pick
	// walk down so the lowest hitting lane is the last to overwrite
	// lanes fill in sprite order, so lowest lane is lowest sprite
	always_comb
	begin
		sel_hit = 1'b0;
		sel_pal = '0;
		for (int i = `SPR_LANES - 1; i >= 0; i--)
		begin
			if (lane_in[i].hit)
			begin
				sel_hit = 1'b1;
				sel_pal = lane_in[i].pal;
			end
		end
	end

	// output register, one cycle after the timer value
	// enable gated by spr_en of the same cycle
	always_ff @(posedge clk, posedge line_start)
	begin
		if (line_start)
		begin
			spixel <= '0;
			spx_en <= 1'b0;
		end
		else
		begin
			spixel <= sel_pal;
			spx_en <= sel_hit && spr_en;
		end
	end

endmodule

/* src/sprite_pkg.sv */
package sprite_pkg;

	// one stored descriptor
	// pattern address and colour resolution are not kept
	typedef struct packed {
		logic       act;
		logic [5:0] pal;
		logic [8:0] xpos;
		logic [6:0] xsz;
		logic [8:0] ypos;
		logic [6:0] ysz;
	} spr_desc_t;

	// horizontal part of a descriptor, handed to a lane
	typedef struct packed {
		logic [8:0] xpos;
		logic [6:0] xsz;
		logic [5:0] pal;
	} lane_load_t;

	// lane answer for the current pixel
	typedef struct packed {
		logic       hit;
		logic [5:0] pal;
	} lane_hit_t;

	// current screen position
	// vis low during blanking
	typedef struct packed {
		logic       vis;
		logic [8:0] x;
	} screen_x_t;

endpackage

/* src/sprite_scan.sv */
`include "sprite_cfg.svh"

module sprite_scan import sprite_pkg::*;
(
	input  logic                  clk,
	input  logic                  line_start,
	input  logic [8:0]            vline,
	input  spr_desc_t             rd_desc,
	output logic [4:0]            rd_addr,
	output logic [`SPR_LANES-1:0] lane_load,
	output lane_load_t            load_data,
	output screen_x_t             screen_x
);

	// width of the loaded lane counter, must reach SPR_LANES
	localparam int CNT_W = $clog2(`SPR_LANES + 1);

	// line timer limits
	localparam logic [8:0] H_LAST = 9'(`LINE_CYCLES - 1);
	localparam logic [8:0] H_VIS  = 9'(`HBLANK_CYCLES);
	localparam logic [9:0] H_END  = 10'(`HBLANK_CYCLES + `VIS_WIDTH);
	localparam logic [8:0] H_SCAN = 9'(`SPR_COUNT);

	logic [8:0]       hcount;
	logic [CNT_W-1:0] used;
	logic             scan_win;
	logic [9:0]       y_end;
	logic             v_hit;
	logic             take;

	// line timer
	// held at 0 by line_start, stops at the last cycle of the line
	always_ff @(posedge clk, posedge line_start)
	begin
		if (line_start)
			hcount <= '0;
		else if (hcount != H_LAST)
			hcount <= hcount + 9'd1;
	end

	// descriptor walk, address h is read during h
	// only 0..31 matter, later values are never tested
	assign rd_addr = hcount[4:0];

	// descriptor for address h-1 is on rd_desc during h
	assign scan_win = (hcount != 9'd0) && (hcount <= H_SCAN);

	// vertical test without wrap, ysz 0 covers nothing
	assign y_end = {1'b0, rd_desc.ypos} + {3'b000, rd_desc.ysz};
	assign v_hit = rd_desc.act
		&& (vline >= rd_desc.ypos)
		&& ({1'b0, vline} < y_end);

	// hits past the last lane are dropped
	assign take = scan_win && v_hit && (used < CNT_W'(`SPR_LANES));

	// count of lanes already holding a sprite this line
	always_ff @(posedge clk, posedge line_start)
	begin
		if (line_start)
			used <= '0;
		else if (take)
			used <= used + CNT_W'(1);
	end

	// one load strobe, to the lowest free lane
	always_comb
	begin
		lane_load = '0;
		for (int i = 0; i < `SPR_LANES; i++)
			lane_load[i] = take && (used == CNT_W'(i));
	end

	// horizontal part goes to whichever lane is strobed
	assign load_data.xpos = rd_desc.xpos;
	assign load_data.xsz  = rd_desc.xsz;
	assign load_data.pal  = rd_desc.pal;

	// screen position broadcast, straight from the timer
	assign screen_x.vis = (hcount >= H_VIS) && ({1'b0, hcount} < H_END);
	assign screen_x.x   = hcount - H_VIS;

endmodule
